/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_emio_bridge
FILELIST  := emio_bridge.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) emio_bridge_cfg.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* emio_bridge.f */
+incdir+.
emio_bridge_pkg.sv
emio_front.sv
emio_read_seq.sv
emio_write_seq.sv
emio_merge.sv
emio_bridge.sv
emio_bridge_chk.sv
tb_emio_bridge.sv

/* emio_bridge.sv */
// EMIO bridge top: front end, read and write sequencers and merge stage
`default_nettype none
`include "emio_bridge_cfg.svh"

module emio_bridge (
    input  wire logic                    sysclk,
    input  wire logic                    rst_n,
    // processor GPIO port
    input  wire logic [63:0]             emio_ps_out,
    input  wire logic [63:0]             emio_ps_tri,
    output logic [63:0]                  emio_ps_in,
    // read bus
    output logic [`EMIO_ADDR_W-1:0]      reg_raddr,
    input  wire logic [`EMIO_DATA_W-1:0] reg_rdata,
    input  wire logic                    reg_rvalid,
    output logic                         req_read_bus,
    input  wire logic                    grant_read_bus,
    // write bus
    output logic [`EMIO_ADDR_W-1:0]      reg_waddr,
    output logic [`EMIO_DATA_W-1:0]      reg_wdata,
    output logic                         reg_wen,
    output logic                         blk_wen,
    output logic                         blk_wstart,
    output logic                         req_write_bus,
    input  wire logic                    grant_write_bus
);

    import emio_bridge_pkg::*;

    ps_cmd_t cmd;
    rd_res_t rd_res;
    wr_res_t wr_res;

    emio_front u_front (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .emio_ps_out (emio_ps_out),
        .emio_ps_tri (emio_ps_tri),
        .cmd         (cmd)
    );

    emio_read_seq u_read_seq (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .cmd            (cmd),
        .reg_rdata      (reg_rdata),
        .reg_rvalid     (reg_rvalid),
        .grant_read_bus (grant_read_bus),
        .req_read_bus   (req_read_bus),
        .res            (rd_res)
    );

    emio_write_seq u_write_seq (
        .sysclk          (sysclk),
        .rst_n           (rst_n),
        .cmd             (cmd),
        .grant_write_bus (grant_write_bus),
        .req_write_bus   (req_write_bus),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .blk_wen         (blk_wen),
        .blk_wstart      (blk_wstart),
        .res             (wr_res)
    );

    emio_merge u_merge (
        .cmd             (cmd),
        .rd              (rd_res),
        .wr              (wr_res),
        .grant_read_bus  (grant_read_bus),
        .grant_write_bus (grant_write_bus),
        .reg_raddr       (reg_raddr),
        .reg_waddr       (reg_waddr),
        .emio_ps_in      (emio_ps_in)
    );

endmodule

`default_nettype wire

/* emio_bridge_cfg.svh */
// widths, EMIO bit positions, version and block-start length of the EMIO bridge
`ifndef EMIO_BRIDGE_CFG_SVH
`define EMIO_BRIDGE_CFG_SVH

// register bus widths
`define EMIO_ADDR_W 16
`define EMIO_DATA_W 32

// EMIO word layout, shared by the processor output and the status word
`define EMIO_ADDR_LO 32
`define EMIO_REQ_BIT 48
`define EMIO_DONE_BIT 49
`define EMIO_BSTART_BIT 51
`define EMIO_BEND_BIT 52
`define EMIO_WRITE_BIT 53
`define EMIO_GRANT_BIT 54
`define EMIO_LSB_BIT 55

// returned in status bits 63:60
`define EMIO_VERSION 4'd1

// granted cycles of blk_wstart ahead of the first block-write quadlet
`define EMIO_BLK_START_CYCLES 4

`endif

/* emio_bridge_chk.sv */
// checker with concurrent assertions on the register-bus strobes, and its bind to the bridge
`default_nettype none

module emio_bridge_chk (
    input wire logic sysclk,
    input wire logic rst_n,
    input wire logic req_read_bus,
    input wire logic req_write_bus,
    input wire logic grant_write_bus,
    input wire logic reg_wen,
    input wire logic blk_wstart
);
    timeunit 1ns;
    timeprecision 1ns;

    // write strobe only on a requested and granted cycle
    wen_granted: assert property (@(posedge sysclk) disable iff (!rst_n)
        reg_wen |-> (req_write_bus && grant_write_bus))
        else $error("reg_wen without a granted write request");

    // one direction at a time
    one_bus: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(req_read_bus && req_write_bus))
        else $error("read and write bus requested together");

    // block start phase ends before the first data strobe
    wstart_apart: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(blk_wstart && reg_wen))
        else $error("blk_wstart overlaps reg_wen");

endmodule

bind emio_bridge emio_bridge_chk chk (
    .sysclk          (sysclk),
    .rst_n           (rst_n),
    .req_read_bus    (req_read_bus),
    .req_write_bus   (req_write_bus),
    .grant_write_bus (grant_write_bus),
    .reg_wen         (reg_wen),
    .blk_wstart      (blk_wstart)
);

`default_nettype wire

/* emio_bridge_pkg.sv */
// packed struct types passed between the EMIO bridge blocks
`default_nettype none
`include "emio_bridge_cfg.svh"

package emio_bridge_pkg;

    // processor command after synchronization
    typedef struct packed {
        // single-cycle edge pulses of the request
        logic                    start;
        logic                    stop;
        // synchronized request level, for the status echo
        logic                    req;
        // no data line tristate
        logic                    write;
        logic [`EMIO_ADDR_W-1:0] addr;
        logic                    addr_lsb;
        logic                    blk_start;
        logic                    blk_end;
        logic [`EMIO_DATA_W-1:0] wdata;
        // raw address still matches the latched one
        logic                    addr_equal;
    } ps_cmd_t;

    // read sequencer result
    typedef struct packed {
        logic                    active;
        logic [`EMIO_ADDR_W-1:0] addr;
        logic                    addr_lsb;
        logic                    done;
        logic [`EMIO_DATA_W-1:0] rdata;
    } rd_res_t;

    // write sequencer result
    typedef struct packed {
        logic                    active;
        logic [`EMIO_ADDR_W-1:0] addr;
        logic                    addr_lsb;
        logic                    done;
    } wr_res_t;

endpackage

`default_nettype wire

/* emio_front.sv */
// EMIO front end: request synchronizer, edge pulses, field latches and read/write decode
`default_nettype none
`include "emio_bridge_cfg.svh"

module emio_front (
    input  wire logic                   sysclk,
    input  wire logic                   rst_n,
    input  wire logic [63:0]            emio_ps_out,
    input  wire logic [63:0]            emio_ps_tri,
    output emio_bridge_pkg::ps_cmd_t    cmd
);

    // request synchronizer and edge history
    logic req_meta;
    logic req_sync;
    logic req_prev;
    logic start_q;
    logic stop_q;

    // latched processor fields
    logic                    write_q;
    logic                    lsb_q;
    logic                    bstart_q;
    logic                    bend_q;
    logic [`EMIO_ADDR_W-1:0] addr_q;
    logic [`EMIO_DATA_W-1:0] wdata_q;
    logic [`EMIO_ADDR_W-1:0] raw_addr;

    assign raw_addr = emio_ps_out[`EMIO_ADDR_LO +: `EMIO_ADDR_W];

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            req_prev <= 1'b0;
            start_q  <= 1'b0;
            stop_q   <= 1'b0;
            write_q  <= 1'b0;
            lsb_q    <= 1'b0;
            bstart_q <= 1'b0;
            bend_q   <= 1'b0;
        end else begin
            req_meta <= emio_ps_out[`EMIO_REQ_BIT];
            req_sync <= req_meta;
            req_prev <= req_sync;
            // edge pulses one cycle after the second flop changes
            start_q  <= req_sync & ~req_prev;
            stop_q   <= ~req_sync & req_prev;
            // write when every data line is driven by the processor
            write_q  <= (emio_ps_tri[`EMIO_DATA_W-1:0] == '0);
            lsb_q    <= emio_ps_out[`EMIO_LSB_BIT];
            bstart_q <= emio_ps_out[`EMIO_BSTART_BIT];
            bend_q   <= emio_ps_out[`EMIO_BEND_BIT];
        end
    end

    // address and data follow the processor word every cycle
    always_ff @(posedge sysclk) begin
        addr_q  <= raw_addr;
        wdata_q <= emio_ps_out[`EMIO_DATA_W-1:0];
    end

    assign cmd.start      = start_q;
    assign cmd.stop       = stop_q;
    assign cmd.req        = req_sync;
    assign cmd.write      = write_q;
    assign cmd.addr       = addr_q;
    assign cmd.addr_lsb   = lsb_q;
    assign cmd.blk_start  = bstart_q;
    assign cmd.blk_end    = bend_q;
    assign cmd.wdata      = wdata_q;
    // low while the processor is still moving the address
    assign cmd.addr_equal = (raw_addr == addr_q);

endmodule

`default_nettype wire

/* emio_merge.sv */
// merge stage: register address, masked op-done and the EMIO status word
`default_nettype none
`include "emio_bridge_cfg.svh"

module emio_merge (
    input  wire emio_bridge_pkg::ps_cmd_t   cmd,
    input  wire emio_bridge_pkg::rd_res_t   rd,
    input  wire emio_bridge_pkg::wr_res_t   wr,
    input  wire logic                       grant_read_bus,
    input  wire logic                       grant_write_bus,
    output logic [`EMIO_ADDR_W-1:0]         reg_raddr,
    output logic [`EMIO_ADDR_W-1:0]         reg_waddr,
    output logic [63:0]                     emio_ps_in
);

    logic [`EMIO_ADDR_W-1:0] sel_addr;
    logic                    sel_lsb;
    logic                    sel_done;
    logic                    op_done;
    logic [63:0]             status;

    // reads and writes never overlap, so one address feeds both buses
    assign sel_addr  = wr.active ? wr.addr : rd.addr;
    assign sel_lsb   = wr.active ? wr.addr_lsb : rd.addr_lsb;
    assign sel_done  = wr.active ? wr.done : rd.done;
    assign reg_raddr = sel_addr;
    assign reg_waddr = sel_addr;

    // op-done masked while the processor moves the address or its lsb
    assign op_done = sel_done & cmd.addr_equal & (sel_lsb == cmd.addr_lsb);

    always_comb begin
        status = '0;
        status[63 -: 4] = `EMIO_VERSION;
        status[`EMIO_LSB_BIT] = cmd.addr_lsb;
        // grant of whichever direction the mask selects
        status[`EMIO_GRANT_BIT] = cmd.write ? grant_write_bus : grant_read_bus;
        status[`EMIO_WRITE_BIT] = cmd.write;
        status[`EMIO_BEND_BIT] = cmd.blk_end;
        status[`EMIO_BSTART_BIT] = cmd.blk_start;
        status[`EMIO_DONE_BIT] = op_done;
        status[`EMIO_REQ_BIT] = cmd.req;
        status[`EMIO_ADDR_LO +: `EMIO_ADDR_W] = cmd.addr;
        // echo of write data, or the last read quadlet
        status[`EMIO_DATA_W-1:0] = cmd.write ? cmd.wdata : rd.rdata;
    end

    assign emio_ps_in = status;

endmodule

`default_nettype wire

/* emio_read_seq.sv */
// read sequencer: quadlet and block reads on the read bus
`default_nettype none
`include "emio_bridge_cfg.svh"

module emio_read_seq (
    input  wire logic                          sysclk,
    input  wire logic                          rst_n,
    input  wire emio_bridge_pkg::ps_cmd_t      cmd,
    input  wire logic [`EMIO_DATA_W-1:0]       reg_rdata,
    input  wire logic                          reg_rvalid,
    input  wire logic                          grant_read_bus,
    output logic                               req_read_bus,
    output emio_bridge_pkg::rd_res_t           res
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_READ,
        RD_HOLD
    } rd_state_t;

    rd_state_t               state;
    logic [`EMIO_ADDR_W-1:0] addr;
    logic                    addr_lsb;
    logic                    done;
    // data captured, done follows next cycle
    logic                    data_ok;
    // bus stays requested after this quadlet
    logic                    keep_req;
    logic                    rd_hit;
    logic [`EMIO_DATA_W-1:0] rdata;

    assign rd_hit = req_read_bus & grant_read_bus & reg_rvalid;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= RD_IDLE;
            req_read_bus <= 1'b0;
            addr         <= '0;
            addr_lsb     <= 1'b0;
            done         <= 1'b0;
            data_ok      <= 1'b0;
            keep_req     <= 1'b0;
        end else if (cmd.stop) begin
            // falling request aborts or ends the transfer
            state        <= RD_IDLE;
            req_read_bus <= 1'b0;
            done         <= 1'b0;
            data_ok      <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (cmd.start && !cmd.write) begin
                        req_read_bus <= 1'b1;
                        addr         <= cmd.addr;
                        addr_lsb     <= cmd.addr_lsb;
                        keep_req     <= cmd.blk_start & ~cmd.blk_end;
                        state        <= RD_READ;
                    end
                end
                RD_READ: begin
                    if (data_ok) begin
                        // last quadlet of a block releases the bus here
                        done         <= 1'b1;
                        req_read_bus <= keep_req;
                        state        <= RD_HOLD;
                    end else if (rd_hit) begin
                        data_ok <= 1'b1;
                    end
                end
                RD_HOLD: begin
                    // lsb toggle asks for the next sequential quadlet
                    if (req_read_bus && (cmd.addr_lsb != addr_lsb)) begin
                        done     <= 1'b0;
                        data_ok  <= 1'b0;
                        addr     <= addr + 1'b1;
                        addr_lsb <= cmd.addr_lsb;
                        keep_req <= cmd.blk_start & ~cmd.blk_end;
                        state    <= RD_READ;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // read data held for the status word
    always_ff @(posedge sysclk) begin
        if ((state == RD_READ) && rd_hit && !data_ok) begin
            rdata <= reg_rdata;
        end
    end

    assign res.active   = (state != RD_IDLE);
    assign res.addr     = addr;
    assign res.addr_lsb = addr_lsb;
    // hidden until the saved lsb catches up with the processor
    assign res.done     = done & (addr_lsb == cmd.addr_lsb);
    assign res.rdata    = rdata;

endmodule

`default_nettype wire

/* emio_write_seq.sv */
// write sequencer: quadlet and block writes on the write bus
`default_nettype none
`include "emio_bridge_cfg.svh"

module emio_write_seq (
    input  wire logic                          sysclk,
    input  wire logic                          rst_n,
    input  wire emio_bridge_pkg::ps_cmd_t      cmd,
    input  wire logic                          grant_write_bus,
    output logic                               req_write_bus,
    output logic [`EMIO_DATA_W-1:0]            reg_wdata,
    output logic                               reg_wen,
    output logic                               blk_wen,
    output logic                               blk_wstart,
    output emio_bridge_pkg::wr_res_t           res
);

    localparam int CNT_W = $clog2(`EMIO_BLK_START_CYCLES + 1);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_QUAD,
        WR_BSTART,
        WR_BDATA,
        WR_FINISH
    } wr_state_t;

    wr_state_t               state;
    logic [`EMIO_ADDR_W-1:0] addr;
    logic                    addr_lsb;
    logic                    done;
    // quadlet waiting for its strobe
    logic                    pend;
    // current quadlet closes the block
    logic                    last;
    logic [CNT_W-1:0]        cnt;
    logic                    strobe;
    logic                    take_cmd;
    logic                    take_next;

    assign strobe    = req_write_bus & grant_write_bus;
    assign take_cmd  = (state == WR_IDLE) & cmd.start & cmd.write;
    // next block quadlet once the previous one went out
    assign take_next = (state == WR_BDATA) & ~pend & (cmd.addr_lsb != addr_lsb);

    // strobes only on granted cycles
    assign blk_wstart = (state == WR_BSTART) & strobe;
    assign reg_wen    = strobe & ((state == WR_QUAD) | ((state == WR_BDATA) & pend));
    assign blk_wen    = reg_wen & ((state == WR_QUAD) | last);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= WR_IDLE;
            req_write_bus <= 1'b0;
            addr          <= '0;
            addr_lsb      <= 1'b0;
            done          <= 1'b0;
            pend          <= 1'b0;
            last          <= 1'b0;
            cnt           <= '0;
        end else if (cmd.stop) begin
            state         <= WR_IDLE;
            req_write_bus <= 1'b0;
            done          <= 1'b0;
            pend          <= 1'b0;
            cnt           <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (take_cmd) begin
                        req_write_bus <= 1'b1;
                        addr          <= cmd.addr;
                        addr_lsb      <= cmd.addr_lsb;
                        last          <= cmd.blk_end;
                        pend          <= 1'b1;
                        cnt           <= '0;
                        state         <= cmd.blk_start ? WR_BSTART : WR_QUAD;
                    end
                end
                WR_QUAD: begin
                    if (strobe) begin
                        done          <= 1'b1;
                        req_write_bus <= 1'b0;
                        state         <= WR_FINISH;
                    end
                end
                WR_BSTART: begin
                    // count restarts whenever grant goes away
                    if (!strobe) begin
                        cnt <= '0;
                    end else if (cnt == CNT_W'(`EMIO_BLK_START_CYCLES - 1)) begin
                        cnt   <= '0;
                        state <= WR_BDATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WR_BDATA: begin
                    if (pend && strobe) begin
                        pend <= 1'b0;
                        done <= 1'b1;
                        if (last) begin
                            req_write_bus <= 1'b0;
                            state         <= WR_FINISH;
                        end
                    end else if (take_next) begin
                        done     <= 1'b0;
                        pend     <= 1'b1;
                        addr     <= addr + 1'b1;
                        addr_lsb <= cmd.addr_lsb;
                        last     <= cmd.blk_end;
                    end
                end
                // bus released, done holds until the request falls
                WR_FINISH: ;
                default:   state <= WR_IDLE;
            endcase
        end
    end

    // write data latched with each new quadlet
    always_ff @(posedge sysclk) begin
        if (take_cmd || take_next) begin
            reg_wdata <= cmd.wdata;
        end
    end

    assign res.active   = (state != WR_IDLE);
    assign res.addr     = addr;
    assign res.addr_lsb = addr_lsb;
    assign res.done     = done;

endmodule

`default_nettype wire

/* tb_emio_bridge.sv */
// testbench for the EMIO bridge: clock, processor driver, register-bus model, reference and compare
`default_nettype none
`include "emio_bridge_cfg.svh"

module tb_emio_bridge;
    timeunit 1ns;
    timeprecision 1ns;

    // 16 transfers and their gaps take a few hundred cycles, with a wide margin
    localparam int MAX_CYCLES = 4000;
    // falling request passes two flops and the edge register, idle on the fourth edge
    localparam int STOP_CYCLES = 4;

    // expected register write, one per reg_wen pulse
    typedef struct packed {
        logic [`EMIO_ADDR_W-1:0] addr;
        logic [`EMIO_DATA_W-1:0] data;
        logic                    last;
        logic [7:0]              wstarts;
    } wr_exp_t;

    logic                    sysclk = 1'b0;
    logic                    rst_n;
    logic [63:0]             emio_ps_out;
    logic [63:0]             emio_ps_tri;
    logic [63:0]             emio_ps_in;
    logic [`EMIO_ADDR_W-1:0] reg_raddr;
    logic [`EMIO_ADDR_W-1:0] reg_waddr;
    logic [`EMIO_DATA_W-1:0] reg_rdata = '0;
    logic [`EMIO_DATA_W-1:0] reg_wdata;
    logic                    reg_rvalid = 1'b0;
    logic                    grant_read_bus = 1'b0;
    logic                    grant_write_bus = 1'b0;
    logic                    req_read_bus;
    logic                    req_write_bus;
    logic                    reg_wen;
    logic                    blk_wen;
    logic                    blk_wstart;

    // processor-side fields, packed into emio_ps_out by drive_ps
    logic                    cur_req = 1'b0;
    logic                    cur_write = 1'b0;
    logic [`EMIO_ADDR_W-1:0] cur_addr = '0;
    logic                    cur_lsb = 1'b0;
    logic                    cur_bstart = 1'b0;
    logic                    cur_bend = 1'b0;
    logic [`EMIO_DATA_W-1:0] cur_wdata = '0;

    // bus model state
    logic                    hold_grant = 1'b0;
    logic [1:0]              rd_wait = 2'd0;
    logic [1:0]              wr_wait = 2'd0;
    logic [31:0]             gnt_rng = 32'd37;
    logic [31:0]             data_rng = 32'd37;
    int                      wstart_cnt = 0;
    wr_exp_t                 exp_wr[$];

    int checks = 0;
    int mismatches = 0;
    int faults = 0;
    int cycles = 0;

    emio_bridge dut (
        .sysclk          (sysclk),
        .rst_n           (rst_n),
        .emio_ps_out     (emio_ps_out),
        .emio_ps_tri     (emio_ps_tri),
        .emio_ps_in      (emio_ps_in),
        .reg_raddr       (reg_raddr),
        .reg_rdata       (reg_rdata),
        .reg_rvalid      (reg_rvalid),
        .req_read_bus    (req_read_bus),
        .grant_read_bus  (grant_read_bus),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .blk_wen         (blk_wen),
        .blk_wstart      (blk_wstart),
        .req_write_bus   (req_write_bus),
        .grant_write_bus (grant_write_bus)
    );

    always #20 sysclk = ~sysclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // register contents: address times an odd constant, xor a pattern
    function automatic logic [31:0] ref_data(input logic [`EMIO_ADDR_W-1:0] addr);
        return ({16'h0, addr} * 32'h9E37_79B1) ^ 32'hA5C3_0F1E;
    endfunction

    // status word expected while op-done is up
    function automatic logic [63:0] status_ref(input logic [`EMIO_DATA_W-1:0] data);
        logic [63:0] w;
        w = '0;
        w[63:60] = `EMIO_VERSION;
        w[`EMIO_LSB_BIT] = cur_lsb;
        // grant of the direction the processor asked for
        w[`EMIO_GRANT_BIT] = cur_write ? grant_write_bus : grant_read_bus;
        w[`EMIO_WRITE_BIT] = cur_write;
        w[`EMIO_BEND_BIT] = cur_bend;
        w[`EMIO_BSTART_BIT] = cur_bstart;
        w[`EMIO_DONE_BIT] = 1'b1;
        w[`EMIO_REQ_BIT] = 1'b1;
        w[`EMIO_ADDR_LO +: `EMIO_ADDR_W] = cur_addr;
        w[`EMIO_DATA_W-1:0] = data;
        return w;
    endfunction

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // read transfers tristate the data lines, writes drive them
    task automatic drive_ps();
        logic [63:0] w;
        w = '0;
        w[`EMIO_REQ_BIT] = cur_req;
        w[`EMIO_LSB_BIT] = cur_lsb;
        w[`EMIO_BSTART_BIT] = cur_bstart;
        w[`EMIO_BEND_BIT] = cur_bend;
        w[`EMIO_ADDR_LO +: `EMIO_ADDR_W] = cur_addr;
        w[`EMIO_DATA_W-1:0] = cur_wdata;
        emio_ps_out = w;
        emio_ps_tri = cur_write ? 64'h0 : {32'h0, 32'hFFFF_FFFF};
    endtask

    task automatic start_op(input logic write, input logic [`EMIO_ADDR_W-1:0] addr,
                            input logic bstart, input logic bend);
        @(negedge sysclk);
        cur_req = 1'b1;
        cur_write = write;
        cur_addr = addr;
        cur_lsb = 1'b0;
        cur_bstart = bstart;
        cur_bend = bend;
        cur_wdata = '0;
        if (write) begin
            data_rng = xorshift32(data_rng);
            cur_wdata = data_rng;
        end
        drive_ps();
    endtask

    // lsb toggle asks for the next quadlet of a block
    task automatic next_quadlet(input logic bend);
        @(negedge sysclk);
        cur_lsb = ~cur_lsb;
        cur_bend = bend;
        if (cur_write) begin
            data_rng = xorshift32(data_rng);
            cur_wdata = data_rng;
        end
        drive_ps();
    endtask

    task automatic wait_done();
        @(negedge sysclk);
        while (!emio_ps_in[`EMIO_DONE_BIT]) begin
            @(negedge sysclk);
        end
    endtask

    // drop the request and wait for the bridge to go idle
    task automatic end_op();
        @(negedge sysclk);
        cur_req = 1'b0;
        drive_ps();
        @(negedge sysclk);
        while (emio_ps_in[`EMIO_REQ_BIT] || emio_ps_in[`EMIO_DONE_BIT] ||
               req_read_bus || req_write_bus) begin
            @(negedge sysclk);
        end
        repeat (2) @(negedge sysclk);
    endtask

    // drop the request mid-transfer and give the stop pulse its fixed latency
    task automatic abort_op();
        @(negedge sysclk);
        cur_req = 1'b0;
        drive_ps();
        repeat (STOP_CYCLES) @(negedge sysclk);
    endtask

    task automatic check_status(input logic [`EMIO_DATA_W-1:0] data);
        compare_value("status word", emio_ps_in, status_ref(data));
    endtask

    task automatic push_write(input logic [`EMIO_ADDR_W-1:0] addr, input logic last,
                              input logic [7:0] wstarts);
        wr_exp_t e;
        e.addr = addr;
        e.data = cur_wdata;
        e.last = last;
        e.wstarts = wstarts;
        exp_wr.push_back(e);
    endtask

    // grant after 0 to 3 cycles, held while the request stays up
    always @(negedge sysclk) begin
        gnt_rng = xorshift32(gnt_rng);
        if (!req_read_bus || hold_grant) begin
            grant_read_bus <= 1'b0;
            rd_wait <= gnt_rng[1:0];
        end else if (rd_wait == 2'd0) begin
            grant_read_bus <= 1'b1;
        end else begin
            rd_wait <= rd_wait - 2'd1;
        end
        if (!req_write_bus || hold_grant) begin
            grant_write_bus <= 1'b0;
            wr_wait <= gnt_rng[3:2];
        end else if (wr_wait == 2'd0) begin
            grant_write_bus <= 1'b1;
        end else begin
            wr_wait <= wr_wait - 2'd1;
        end
        // read data valid on every granted cycle
        reg_rvalid <= req_read_bus && !hold_grant && (rd_wait == 2'd0);
        reg_rdata <= ref_data(reg_raddr);
    end

    // each write strobe against the next expected write
    always @(posedge sysclk) begin : write_compare
        wr_exp_t e;
        if (blk_wstart) begin
            wstart_cnt++;
        end
        if (reg_wen) begin
            if (exp_wr.size() == 0) begin
                faults++;
                $display("reg_wen at %0t ns while no write was expected", $time);
            end else begin
                e = exp_wr.pop_front();
                compare_value("write address", 64'(reg_waddr), 64'(e.addr));
                compare_value("write data", 64'(reg_wdata), 64'(e.data));
                compare_value("blk_wen", 64'(blk_wen), 64'(e.last));
                compare_value("blk_wstart cycles", 64'(wstart_cnt), 64'(e.wstarts));
            end
            wstart_cnt = 0;
        end else if (blk_wen) begin
            faults++;
            $display("blk_wen at %0t ns without a reg_wen strobe", $time);
        end
    end

    initial begin : watchdog
        while (cycles < MAX_CYCLES) begin
            @(posedge sysclk);
            cycles++;
        end
        $display("timeout: run not finished after %0d cycles, %0d mismatches, %0d other errors",
                 cycles, mismatches, faults);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        int i;
        logic [`EMIO_ADDR_W-1:0] base;
        rst_n = 1'b0;
        drive_ps();
        repeat (3) @(negedge sysclk);
        rst_n = 1'b1;
        repeat (2) @(negedge sysclk);

        // quadlet read
        start_op(1'b0, 16'h0040, 1'b0, 1'b0);
        wait_done();
        compare_value("read address", 64'(reg_raddr), 64'(16'h0040));
        check_status(ref_data(16'h0040));
        end_op();

        // quadlet write, one strobe with blk_wen
        start_op(1'b1, 16'h0100, 1'b0, 1'b0);
        push_write(16'h0100, 1'b1, 8'd0);
        wait_done();
        check_status(cur_wdata);
        compare_value("writes pending after quadlet", 64'(exp_wr.size()), 64'd0);
        end_op();

        // block read of 6 quadlets
        base = 16'h0200;
        start_op(1'b0, base, 1'b1, 1'b0);
        for (i = 0; i < 6; i++) begin
            if (i > 0) begin
                next_quadlet(i == 5);
            end
            wait_done();
            compare_value("block read address", 64'(reg_raddr), 64'(base + 16'(i)));
            check_status(ref_data(base + 16'(i)));
        end
        compare_value("req_read_bus after block", 64'(req_read_bus), 64'd0);
        end_op();

        // block write of 5 quadlets, start cycles ahead of the first
        base = 16'h0300;
        start_op(1'b1, base, 1'b1, 1'b0);
        push_write(base, 1'b0, 8'(`EMIO_BLK_START_CYCLES));
        for (i = 0; i < 5; i++) begin
            if (i > 0) begin
                next_quadlet(i == 4);
                push_write(base + 16'(i), i == 4, 8'd0);
            end
            wait_done();
            check_status(cur_wdata);
        end
        compare_value("writes pending after block", 64'(exp_wr.size()), 64'd0);
        end_op();

        // abort a read and a block write while grant stays low
        hold_grant <= 1'b1;
        start_op(1'b0, 16'h0400, 1'b1, 1'b0);
        while (!req_read_bus) begin
            @(negedge sysclk);
        end
        repeat (2) @(negedge sysclk);
        compare_value("op-done while stalled", 64'(emio_ps_in[`EMIO_DONE_BIT]), 64'd0);
        abort_op();
        compare_value("req_read_bus after abort", 64'(req_read_bus), 64'd0);
        start_op(1'b1, 16'h0480, 1'b1, 1'b0);
        while (!req_write_bus) begin
            @(negedge sysclk);
        end
        repeat (2) @(negedge sysclk);
        abort_op();
        compare_value("req_write_bus after abort", 64'(req_write_bus), 64'd0);
        compare_value("op-done after abort", 64'(emio_ps_in[`EMIO_DONE_BIT]), 64'd0);
        hold_grant <= 1'b0;

        // bridge still usable after the aborts
        start_op(1'b0, 16'h0500, 1'b0, 1'b0);
        wait_done();
        check_status(ref_data(16'h0500));
        end_op();

        if (exp_wr.size() != 0) begin
            faults++;
            $display("%0d expected register writes never reached the bus", exp_wr.size());
        end
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, faults);
        if (mismatches == 0 && faults == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
